/* Makefile */
# Verilator build of the ext_bus testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal --top-module tb_ext_bus -Mdir $(OBJ_DIR) -f tb.f

run: compile
	./$(OBJ_DIR)/Vtb_ext_bus

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_ext_bus.sv */
// Testbench for ext_bus; word addresses only, slaves are behavioral memories with random timing
`default_nettype none

module tb_ext_bus;

  localparam int NM          = bus_pkg::XBAR_NMASTER;
  localparam int NS          = bus_pkg::EXT_NSLAVE;
  localparam int CORE        = bus_pkg::CORE_DATA_IDX;
  localparam int DMA         = bus_pkg::DMA_IDX;
  localparam int EXT         = bus_pkg::SYS_NMASTER;
  localparam int INT_TGT     = NS;
  localparam int N_XFER      = 120;
  localparam int WORST_LAT   = 10;
  localparam int CYCLE_LIMIT = N_XFER * WORST_LAT * 4;

  typedef struct packed {
    logic                       we;
    logic [1:0]                 tgt;
    logic [bus_pkg::DATA_W-1:0] data;
  } exp_t;

  logic clk_i;
  logic rst_n;
  bus_pkg::addr_rule_t [NS-1:0]       addr_map;
  logic [bus_pkg::SLV_IDX_W-1:0]      default_idx;

  logic                       m_req [NM];
  logic                       m_we [NM];
  logic [bus_pkg::ADDR_W-1:0] m_addr [NM];
  logic [bus_pkg::DATA_W-1:0] m_wdata [NM];
  logic                       m_gnt [NM];
  logic                       m_rvalid [NM];
  logic [bus_pkg::DATA_W-1:0] m_rdata [NM];

  logic                       int_req, int_we, int_gnt, int_rvalid;
  logic [bus_pkg::ADDR_W-1:0] int_addr;
  logic [bus_pkg::DATA_W-1:0] int_wdata, int_rdata;

  logic [NS-1:0]                      ext_req, ext_we, ext_gnt, ext_rvalid;
  logic [NS-1:0][bus_pkg::ADDR_W-1:0] ext_addr;
  logic [NS-1:0][bus_pkg::DATA_W-1:0] ext_wdata, ext_rdata;

  logic [bus_pkg::DATA_W-1:0] shadow [logic [bus_pkg::ADDR_W+1:0]];
  exp_t                       exp_q [NM][$];
  int                         seed = 32'ha385cd83;
  int                         cycle;

  always #50 clk_i = ~clk_i;

  ext_bus UUT (
    .clk_i (clk_i), .rst_ni (rst_n), .addr_map_i (addr_map), .default_idx_i (default_idx),
    .core_req_i (m_req[CORE]), .core_we_i (m_we[CORE]), .core_addr_i (m_addr[CORE]),
    .core_wdata_i (m_wdata[CORE]), .core_gnt_o (m_gnt[CORE]),
    .core_rvalid_o (m_rvalid[CORE]), .core_rdata_o (m_rdata[CORE]),
    .dma_req_i (m_req[DMA]), .dma_we_i (m_we[DMA]), .dma_addr_i (m_addr[DMA]),
    .dma_wdata_i (m_wdata[DMA]), .dma_gnt_o (m_gnt[DMA]),
    .dma_rvalid_o (m_rvalid[DMA]), .dma_rdata_o (m_rdata[DMA]),
    .ext_mst_req_i (m_req[EXT]), .ext_mst_we_i (m_we[EXT]), .ext_mst_addr_i (m_addr[EXT]),
    .ext_mst_wdata_i (m_wdata[EXT]), .ext_mst_gnt_o (m_gnt[EXT]),
    .ext_mst_rvalid_o (m_rvalid[EXT]), .ext_mst_rdata_o (m_rdata[EXT]),
    .int_slv_req_o (int_req), .int_slv_we_o (int_we), .int_slv_addr_o (int_addr),
    .int_slv_wdata_o (int_wdata), .int_slv_gnt_i (int_gnt),
    .int_slv_rvalid_i (int_rvalid), .int_slv_rdata_i (int_rdata),
    .ext_slv_req_o (ext_req), .ext_slv_we_o (ext_we), .ext_slv_addr_o (ext_addr),
    .ext_slv_wdata_o (ext_wdata), .ext_slv_gnt_i (ext_gnt),
    .ext_slv_rvalid_i (ext_rvalid), .ext_slv_rdata_i (ext_rdata)
  );

  for (genvar s = 0; s < NS; s++) begin : gen_ext_slv
    tb_mem_slave #(.SLV_ID (s), .SEED (32'ha385cd83 ^ 32'(s + 1))) u_ext_slv (
      .clk_i (clk_i), .rst_ni (rst_n), .req_i (ext_req[s]), .we_i (ext_we[s]),
      .addr_i (ext_addr[s]), .wdata_i (ext_wdata[s]), .gnt_o (ext_gnt[s]),
      .rvalid_o (ext_rvalid[s]), .rdata_o (ext_rdata[s])
    );
  end

  tb_mem_slave #(.SLV_ID (INT_TGT), .SEED (32'ha385cd83 ^ 32'h10)) u_int_slv (
    .clk_i (clk_i), .rst_ni (rst_n), .req_i (int_req), .we_i (int_we),
    .addr_i (int_addr), .wdata_i (int_wdata), .gnt_o (int_gnt),
    .rvalid_o (int_rvalid), .rdata_o (int_rdata)
  );

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] fill_word(int tgt, logic [31:0] addr);
    return addr ^ 32'hc3a5_0f1e ^ (32'(tgt) << 24);
  endfunction

  // Internal port only for the external master outside its window
  function automatic int expected_slave(int m, logic [31:0] addr);
    int tgt;
    if (m == EXT && !(addr >= bus_pkg::FWD_EXT_RULE.start_addr &&
                      addr < bus_pkg::FWD_EXT_RULE.end_addr)) begin
      return INT_TGT;
    end
    tgt = int'(default_idx);
    for (int r = 0; r < NS; r++) begin
      if (addr >= addr_map[r].start_addr && addr < addr_map[r].end_addr) begin
        tgt = int'(addr_map[r].idx);
      end
    end
    return tgt;
  endfunction

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_data(string name, logic [bus_pkg::DATA_W-1:0] got,
                            logic [bus_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_slave(string name, logic [bus_pkg::SLV_IDX_W-1:0] got,
                             logic [bus_pkg::SLV_IDX_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Master driver called right after a rising edge
  // ------------------------------------------------------------
  task automatic issue(int m, logic we, logic [31:0] addr, logic [31:0] wdata);
    exp_t                     e;
    int                       tgt;
    logic [bus_pkg::ADDR_W+1:0] key;
    m_req[m]   <= 1'b1;
    m_we[m]    <= we;
    m_addr[m]  <= addr;
    m_wdata[m] <= wdata;
    do @(posedge clk_i); while (!m_gnt[m]);
    tgt   = expected_slave(m, addr);
    key   = {2'(tgt), addr};
    e.we  = we;
    e.tgt = 2'(tgt);
    if (we) begin
      shadow[key] = wdata;
      e.data      = 32'(tgt);
    end else begin
      e.data = shadow.exists(key) ? shadow[key] : fill_word(tgt, addr);
    end
    exp_q[m].push_back(e);
    m_req[m] <= 1'b0;
  endtask

  task automatic write_read(int m, logic [31:0] addr);
    issue(m, 1'b1, addr, $random(seed));
    issue(m, 1'b0, addr, '0);
  endtask

  function automatic logic [31:0] rand_off();
    return (32'($random(seed)) & 32'hff) << 2;
  endfunction

  task automatic wait_idle();
    while (exp_q[CORE].size() + exp_q[DMA].size() + exp_q[EXT].size() != 0) @(posedge clk_i);
  endtask

  task automatic stream(int m, logic [31:0] base);
    for (int i = 0; i < 8; i++) write_read(m, base + rand_off());
  endtask

  // Responses must follow each master's issue order
  always @(posedge clk_i) begin : compare_resp
    exp_t e;
    if (rst_n) begin
      for (int m = 0; m < NM; m++) begin
        if (m_rvalid[m]) begin
          if (exp_q[m].size() == 0) begin
            stop_run($sformatf("master %0d got a response it never asked for", m));
          end
          e = exp_q[m].pop_front();
          if (!e.we || e.tgt == 2'(INT_TGT)) begin
            check_data($sformatf("rdata[%0d]", m), m_rdata[m], e.data);
          end else begin
            check_slave($sformatf("slave[%0d]", m), m_rdata[m][bus_pkg::SLV_IDX_W-1:0],
                        e.tgt[bus_pkg::SLV_IDX_W-1:0]);
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) stop_run("timeout: transfers did not complete");
  end

  initial begin : main
    logic [31:0] a [8];
    logic [31:0] b [8];
    clk_i = 1'b0;
    rst_n <= 1'b0;
    default_idx = 1;
    addr_map[0] = '{idx: 4'd0, start_addr: 32'h4000_0000, end_addr: 32'h5000_0000};
    addr_map[1] = '{idx: 4'd1, start_addr: 32'h6000_0000, end_addr: 32'h7000_0000};
    for (int m = 0; m < NM; m++) begin
      m_req[m]   <= 1'b0;
      m_we[m]    <= 1'b0;
      m_addr[m]  <= '0;
      m_wdata[m] <= '0;
    end
    repeat (5) @(posedge clk_i);
    rst_n <= 1'b1;
    @(posedge clk_i);

    // Core round trips on both mapped slaves, then unmapped addresses
    for (int i = 0; i < 4; i++) begin
      write_read(CORE, 32'h4000_0000 + rand_off());
      write_read(CORE, 32'h6000_0000 + rand_off());
    end
    for (int i = 0; i < 4; i++) write_read(CORE, 32'h2000_0000 + rand_off());

    // External master inside and outside the forward window, read back after all writes
    for (int i = 0; i < 4; i++) begin
      a[i] = 32'h6000_1000 + rand_off();
      b[i] = 32'h1000_0000 + rand_off();
      issue(EXT, 1'b1, a[i], $random(seed));
      issue(EXT, 1'b1, b[i], $random(seed));
    end
    for (int i = 0; i < 4; i++) begin
      issue(EXT, 1'b0, a[i], '0);
      issue(EXT, 1'b0, b[i], '0);
    end
    wait_idle();

    // All three masters stream at slave 0
    fork
      stream(CORE, 32'h4000_2000);
      stream(DMA, 32'h4000_4000);
      stream(EXT, 32'h4000_6000);
    join
    wait_idle();

    // Alternating targets force the demux to drain between switches
    for (int i = 0; i < 8; i++) begin
      a[i] = 32'h4000_8000 + 32'(i * 4);
      b[i] = 32'h6000_8000 + 32'(i * 4);
      issue(CORE, 1'b1, a[i], $random(seed));
      issue(CORE, 1'b1, b[i], $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      issue(CORE, 1'b0, a[i], '0);
      issue(CORE, 1'b0, b[i], '0);
    end
    wait_idle();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_mem_slave.sv */
// Memory slave model; grant stalls at most 3 cycles, responses in order, write response carries SLV_ID
`default_nettype none

module tb_mem_slave #(
  parameter int unsigned SLV_ID = 0,
  parameter logic [31:0] SEED   = 32'ha385cd83
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       req_i,
  input  wire logic                       we_i,
  input  wire logic [bus_pkg::ADDR_W-1:0] addr_i,
  input  wire logic [bus_pkg::DATA_W-1:0] wdata_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]      rdata_o
);

  typedef struct packed {
    int                         due;
    logic [bus_pkg::DATA_W-1:0] data;
  } rsp_t;

  logic [bus_pkg::DATA_W-1:0] mem [logic [bus_pkg::ADDR_W-1:0]];
  rsp_t                       rsp_q [$];
  int                         seed = SEED;
  int                         cyc;
  int                         last_due;
  int                         stall_cnt;

  always @(posedge clk_i or negedge rst_ni) begin : slave_proc
    rsp_t r;
    if (!rst_ni) begin
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      cyc       = 0;
      last_due  = 0;
      stall_cnt = 0;
      rsp_q.delete();
    end else begin
      cyc = cyc + 1;
      // Accept on the gnt value of the cycle just ended
      if (req_i && gnt_o) begin
        if (we_i) begin
          mem[addr_i] = wdata_i;
          r.data = 32'(SLV_ID);
        end else if (mem.exists(addr_i)) begin
          r.data = mem[addr_i];
        end else begin
          r.data = addr_i ^ 32'hc3a5_0f1e ^ (32'(SLV_ID) << 24);
        end
        r.due = cyc + ($random(seed) & 3);
        if (r.due <= last_due) r.due = last_due + 1;
        last_due = r.due;
        rsp_q.push_back(r);
      end
      rvalid_o <= 1'b0;
      if (rsp_q.size() != 0 && rsp_q[0].due <= cyc) begin
        r = rsp_q.pop_front();
        rvalid_o <= 1'b1;
        rdata_o  <= r.data;
      end
      // Random grant stall, bounded in length
      if (stall_cnt < 3 && ($random(seed) & 3) == 0) begin
        gnt_o     <= 1'b0;
        stall_cnt = stall_cnt + 1;
      end else begin
        gnt_o     <= 1'b1;
        stall_cnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/bus_pkg.sv */
// Bus sizes, crossbar indexes and address rules; rule end addresses are exclusive
`default_nettype none

package bus_pkg;

  // ------------------------------------------------------------
  // Widths and counts
  // ------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  localparam int unsigned SYS_NMASTER  = 2;
  localparam int unsigned EXT_NMASTER  = 1;
  localparam int unsigned XBAR_NMASTER = SYS_NMASTER + EXT_NMASTER;
  localparam int unsigned EXT_NSLAVE   = 2;

  localparam int unsigned SLV_IDX_W = (EXT_NSLAVE > 1) ? $clog2(EXT_NSLAVE) : 1;
  localparam int unsigned MST_IDX_W = (XBAR_NMASTER > 1) ? $clog2(XBAR_NMASTER) : 1;

  // Rule index field, wide enough for any target count used here
  localparam int unsigned RULE_IDX_W = 4;

  // ------------------------------------------------------------
  // Master positions and forward router outputs
  // ------------------------------------------------------------
  localparam int unsigned CORE_DATA_IDX = 0;
  localparam int unsigned DMA_IDX       = 1;

  localparam int unsigned FWD_INT_IDX = 0;
  localparam int unsigned FWD_EXT_IDX = 1;

  // Outstanding transfers per demux and order queue depth
  localparam int unsigned MAX_PENDING = 4;
  localparam int unsigned ORDER_DEPTH = 4;

  typedef struct packed {
    logic [RULE_IDX_W-1:0] idx;
    logic [ADDR_W-1:0]     start_addr;
    logic [ADDR_W-1:0]     end_addr;
  } addr_rule_t;

  // External address window seen by the forward router
  localparam addr_rule_t FWD_EXT_RULE = '{
    idx:        RULE_IDX_W'(FWD_EXT_IDX),
    start_addr: 32'h4000_0000,
    end_addr:   32'h8000_0000
  };

endpackage

`default_nettype wire

/* src/ext_bus.sv */
// External bus top; a single external master, which reaches the crossbar only inside FWD_EXT_RULE
`default_nettype none

module ext_bus (
  input  wire logic                                                clk_i,
  input  wire logic                                                rst_ni,
  input  wire bus_pkg::addr_rule_t [bus_pkg::EXT_NSLAVE-1:0]       addr_map_i,
  input  wire logic [bus_pkg::SLV_IDX_W-1:0]                       default_idx_i,

  // Core data master
  input  wire logic                                                core_req_i,
  input  wire logic                                                core_we_i,
  input  wire logic [bus_pkg::ADDR_W-1:0]                          core_addr_i,
  input  wire logic [bus_pkg::DATA_W-1:0]                          core_wdata_i,
  output logic                                                     core_gnt_o,
  output logic                                                     core_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]                               core_rdata_o,

  // DMA master
  input  wire logic                                                dma_req_i,
  input  wire logic                                                dma_we_i,
  input  wire logic [bus_pkg::ADDR_W-1:0]                          dma_addr_i,
  input  wire logic [bus_pkg::DATA_W-1:0]                          dma_wdata_i,
  output logic                                                     dma_gnt_o,
  output logic                                                     dma_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]                               dma_rdata_o,

  // External master
  input  wire logic                                                ext_mst_req_i,
  input  wire logic                                                ext_mst_we_i,
  input  wire logic [bus_pkg::ADDR_W-1:0]                          ext_mst_addr_i,
  input  wire logic [bus_pkg::DATA_W-1:0]                          ext_mst_wdata_i,
  output logic                                                     ext_mst_gnt_o,
  output logic                                                     ext_mst_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]                               ext_mst_rdata_o,

  // Internal slave port of the microcontroller
  output logic                                                     int_slv_req_o,
  output logic                                                     int_slv_we_o,
  output logic [bus_pkg::ADDR_W-1:0]                               int_slv_addr_o,
  output logic [bus_pkg::DATA_W-1:0]                               int_slv_wdata_o,
  input  wire logic                                                int_slv_gnt_i,
  input  wire logic                                                int_slv_rvalid_i,
  input  wire logic [bus_pkg::DATA_W-1:0]                          int_slv_rdata_i,

  // External slaves
  output logic [bus_pkg::EXT_NSLAVE-1:0]                           ext_slv_req_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0]                           ext_slv_we_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::ADDR_W-1:0]      ext_slv_addr_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::DATA_W-1:0]      ext_slv_wdata_o,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0]                      ext_slv_gnt_i,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0]                      ext_slv_rvalid_i,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::DATA_W-1:0] ext_slv_rdata_i
);

  localparam int unsigned NM      = bus_pkg::XBAR_NMASTER;
  localparam int unsigned EXT_POS = bus_pkg::SYS_NMASTER;
  localparam int unsigned F_INT   = bus_pkg::FWD_INT_IDX;
  localparam int unsigned F_EXT   = bus_pkg::FWD_EXT_IDX;

  logic [NM-1:0]                      mst_req, mst_we, mst_gnt, mst_rvalid;
  logic [NM-1:0][bus_pkg::ADDR_W-1:0] mst_addr;
  logic [NM-1:0][bus_pkg::DATA_W-1:0] mst_wdata, mst_rdata;

  logic [1:0]                      fwd_req, fwd_we, fwd_gnt, fwd_rvalid;
  logic [1:0][bus_pkg::ADDR_W-1:0] fwd_addr;
  logic [1:0][bus_pkg::DATA_W-1:0] fwd_wdata, fwd_rdata;

  // ------------------------------------------------------------
  // Crossbar master ports
  // ------------------------------------------------------------
  assign mst_req[bus_pkg::CORE_DATA_IDX]   = core_req_i;
  assign mst_we[bus_pkg::CORE_DATA_IDX]    = core_we_i;
  assign mst_addr[bus_pkg::CORE_DATA_IDX]  = core_addr_i;
  assign mst_wdata[bus_pkg::CORE_DATA_IDX] = core_wdata_i;
  assign core_gnt_o    = mst_gnt[bus_pkg::CORE_DATA_IDX];
  assign core_rvalid_o = mst_rvalid[bus_pkg::CORE_DATA_IDX];
  assign core_rdata_o  = mst_rdata[bus_pkg::CORE_DATA_IDX];

  assign mst_req[bus_pkg::DMA_IDX]   = dma_req_i;
  assign mst_we[bus_pkg::DMA_IDX]    = dma_we_i;
  assign mst_addr[bus_pkg::DMA_IDX]  = dma_addr_i;
  assign mst_wdata[bus_pkg::DMA_IDX] = dma_wdata_i;
  assign dma_gnt_o    = mst_gnt[bus_pkg::DMA_IDX];
  assign dma_rvalid_o = mst_rvalid[bus_pkg::DMA_IDX];
  assign dma_rdata_o  = mst_rdata[bus_pkg::DMA_IDX];

  // External master enters the crossbar after the system masters
  assign mst_req[EXT_POS]   = fwd_req[F_EXT];
  assign mst_we[EXT_POS]    = fwd_we[F_EXT];
  assign mst_addr[EXT_POS]  = fwd_addr[F_EXT];
  assign mst_wdata[EXT_POS] = fwd_wdata[F_EXT];
  assign fwd_gnt[F_EXT]     = mst_gnt[EXT_POS];
  assign fwd_rvalid[F_EXT]  = mst_rvalid[EXT_POS];
  assign fwd_rdata[F_EXT]   = mst_rdata[EXT_POS];

  assign int_slv_req_o     = fwd_req[F_INT];
  assign int_slv_we_o      = fwd_we[F_INT];
  assign int_slv_addr_o    = fwd_addr[F_INT];
  assign int_slv_wdata_o   = fwd_wdata[F_INT];
  assign fwd_gnt[F_INT]    = int_slv_gnt_i;
  assign fwd_rvalid[F_INT] = int_slv_rvalid_i;
  assign fwd_rdata[F_INT]  = int_slv_rdata_i;

  // ------------------------------------------------------------
  // Forward router and crossbar
  // ------------------------------------------------------------
  obi_demux #(
    .NTARGET (2),
    .NRULES  (1),
    .IDX_W   (1)
  ) u_fwd_router (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rules_i       (bus_pkg::FWD_EXT_RULE),
    .default_idx_i (1'(bus_pkg::FWD_INT_IDX)),
    .req_i         (ext_mst_req_i),
    .we_i          (ext_mst_we_i),
    .addr_i        (ext_mst_addr_i),
    .wdata_i       (ext_mst_wdata_i),
    .gnt_o         (ext_mst_gnt_o),
    .rvalid_o      (ext_mst_rvalid_o),
    .rdata_o       (ext_mst_rdata_o),
    .req_o         (fwd_req),
    .we_o          (fwd_we),
    .addr_o        (fwd_addr),
    .wdata_o       (fwd_wdata),
    .gnt_i         (fwd_gnt),
    .rvalid_i      (fwd_rvalid),
    .rdata_i       (fwd_rdata)
  );

  ext_xbar u_ext_xbar (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .addr_map_i    (addr_map_i),
    .default_idx_i (default_idx_i),
    .req_i         (mst_req),
    .we_i          (mst_we),
    .addr_i        (mst_addr),
    .wdata_i       (mst_wdata),
    .gnt_o         (mst_gnt),
    .rvalid_o      (mst_rvalid),
    .rdata_o       (mst_rdata),
    .req_o         (ext_slv_req_o),
    .we_o          (ext_slv_we_o),
    .addr_o        (ext_slv_addr_o),
    .wdata_o       (ext_slv_wdata_o),
    .gnt_i         (ext_slv_gnt_i),
    .rvalid_i      (ext_slv_rvalid_i),
    .rdata_i       (ext_slv_rdata_i)
  );

endmodule

`default_nettype wire

/* src/ext_xbar.sv */
// Full crossbar of XBAR_NMASTER masters onto EXT_NSLAVE slaves, no added request latency
`default_nettype none

module ext_xbar (
  input  wire logic                                                  clk_i,
  input  wire logic                                                  rst_ni,
  input  wire bus_pkg::addr_rule_t [bus_pkg::EXT_NSLAVE-1:0]         addr_map_i,
  input  wire logic [bus_pkg::SLV_IDX_W-1:0]                         default_idx_i,
  input  wire logic [bus_pkg::XBAR_NMASTER-1:0]                      req_i,
  input  wire logic [bus_pkg::XBAR_NMASTER-1:0]                      we_i,
  input  wire logic [bus_pkg::XBAR_NMASTER-1:0][bus_pkg::ADDR_W-1:0] addr_i,
  input  wire logic [bus_pkg::XBAR_NMASTER-1:0][bus_pkg::DATA_W-1:0] wdata_i,
  output logic [bus_pkg::XBAR_NMASTER-1:0]                           gnt_o,
  output logic [bus_pkg::XBAR_NMASTER-1:0]                           rvalid_o,
  output logic [bus_pkg::XBAR_NMASTER-1:0][bus_pkg::DATA_W-1:0]      rdata_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0]                             req_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0]                             we_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::ADDR_W-1:0]        addr_o,
  output logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::DATA_W-1:0]        wdata_o,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0]                        gnt_i,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0]                        rvalid_i,
  input  wire logic [bus_pkg::EXT_NSLAVE-1:0][bus_pkg::DATA_W-1:0]   rdata_i
);

  localparam int unsigned NM = bus_pkg::XBAR_NMASTER;
  localparam int unsigned NS = bus_pkg::EXT_NSLAVE;

  // Demux side, indexed [master][slave]
  logic [NM-1:0][NS-1:0]                      dmx_req, dmx_we, dmx_gnt, dmx_rvalid;
  logic [NM-1:0][NS-1:0][bus_pkg::ADDR_W-1:0] dmx_addr;
  logic [NM-1:0][NS-1:0][bus_pkg::DATA_W-1:0] dmx_wdata, dmx_rdata;

  // Arbiter side, indexed [slave][master]
  logic [NS-1:0][NM-1:0]                      arb_req, arb_we, arb_gnt, arb_rvalid;
  logic [NS-1:0][NM-1:0][bus_pkg::ADDR_W-1:0] arb_addr;
  logic [NS-1:0][NM-1:0][bus_pkg::DATA_W-1:0] arb_wdata, arb_rdata;

  for (genvar m = 0; m < NM; m++) begin : gen_demux
    obi_demux #(
      .NTARGET (NS),
      .NRULES  (NS),
      .IDX_W   (bus_pkg::SLV_IDX_W)
    ) u_demux (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .rules_i       (addr_map_i),
      .default_idx_i (default_idx_i),
      .req_i         (req_i[m]),
      .we_i          (we_i[m]),
      .addr_i        (addr_i[m]),
      .wdata_i       (wdata_i[m]),
      .gnt_o         (gnt_o[m]),
      .rvalid_o      (rvalid_o[m]),
      .rdata_o       (rdata_o[m]),
      .req_o         (dmx_req[m]),
      .we_o          (dmx_we[m]),
      .addr_o        (dmx_addr[m]),
      .wdata_o       (dmx_wdata[m]),
      .gnt_i         (dmx_gnt[m]),
      .rvalid_i      (dmx_rvalid[m]),
      .rdata_i       (dmx_rdata[m])
    );
  end

  // Transposed mesh between demuxes and arbiters
  for (genvar s = 0; s < NS; s++) begin : gen_mesh_s
    for (genvar m = 0; m < NM; m++) begin : gen_mesh_m
      assign arb_req[s][m]    = dmx_req[m][s];
      assign arb_we[s][m]     = dmx_we[m][s];
      assign arb_addr[s][m]   = dmx_addr[m][s];
      assign arb_wdata[s][m]  = dmx_wdata[m][s];
      assign dmx_gnt[m][s]    = arb_gnt[s][m];
      assign dmx_rvalid[m][s] = arb_rvalid[s][m];
      assign dmx_rdata[m][s]  = arb_rdata[s][m];
    end
  end

  for (genvar s = 0; s < NS; s++) begin : gen_arbiter
    obi_rr_arbiter #(
      .NMASTER (NM),
      .IDX_W   (bus_pkg::MST_IDX_W)
    ) u_arbiter (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .req_i    (arb_req[s]),
      .we_i     (arb_we[s]),
      .addr_i   (arb_addr[s]),
      .wdata_i  (arb_wdata[s]),
      .gnt_o    (arb_gnt[s]),
      .rvalid_o (arb_rvalid[s]),
      .rdata_o  (arb_rdata[s]),
      .req_o    (req_o[s]),
      .we_o     (we_o[s]),
      .addr_o   (addr_o[s]),
      .wdata_o  (wdata_o[s]),
      .gnt_i    (gnt_i[s]),
      .rvalid_i (rvalid_i[s]),
      .rdata_i  (rdata_i[s])
    );
  end

endmodule

`default_nettype wire

/* src/obi_demux.sv */
// One-to-N router; IDX_W must not exceed the rule index width, a target change waits for drain
`default_nettype none

module obi_demux #(
  parameter int unsigned NTARGET = 2,
  parameter int unsigned NRULES  = 1,
  parameter int unsigned IDX_W   = bus_pkg::SLV_IDX_W
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire bus_pkg::addr_rule_t [NRULES-1:0]       rules_i,
  input  wire logic [IDX_W-1:0]                       default_idx_i,
  input  wire logic                                   req_i,
  input  wire logic                                   we_i,
  input  wire logic [bus_pkg::ADDR_W-1:0]             addr_i,
  input  wire logic [bus_pkg::DATA_W-1:0]             wdata_i,
  output logic                                        gnt_o,
  output logic                                        rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]                  rdata_o,
  output logic [NTARGET-1:0]                          req_o,
  output logic [NTARGET-1:0]                          we_o,
  output logic [NTARGET-1:0][bus_pkg::ADDR_W-1:0]     addr_o,
  output logic [NTARGET-1:0][bus_pkg::DATA_W-1:0]     wdata_o,
  input  wire logic [NTARGET-1:0]                     gnt_i,
  input  wire logic [NTARGET-1:0]                     rvalid_i,
  input  wire logic [NTARGET-1:0][bus_pkg::DATA_W-1:0] rdata_i
);

  localparam int unsigned CNT_W = $clog2(bus_pkg::MAX_PENDING + 1);

  logic [IDX_W-1:0] sel_idx;
  logic [IDX_W-1:0] cur_idx_q;
  logic [CNT_W-1:0] pending_q;
  logic             can_issue;
  logic             accept;

  // Address decode, later rules take priority
  always_comb begin
    sel_idx = default_idx_i;
    for (int r = 0; r < NRULES; r++) begin
      if (addr_i >= rules_i[r].start_addr && addr_i < rules_i[r].end_addr) begin
        sel_idx = rules_i[r].idx[IDX_W-1:0];
      end
    end
  end

  // Same target as the pending transfers, or nothing pending
  assign can_issue = ((pending_q == '0) || (sel_idx == cur_idx_q)) &&
                     (pending_q < CNT_W'(bus_pkg::MAX_PENDING));

  always_comb begin
    for (int t = 0; t < NTARGET; t++) begin
      req_o[t]   = req_i && can_issue && (sel_idx == IDX_W'(t));
      we_o[t]    = we_i;
      addr_o[t]  = addr_i;
      wdata_o[t] = wdata_i;
    end
  end

  assign gnt_o  = req_i && can_issue && gnt_i[sel_idx];
  assign accept = gnt_o;

  // Responses can only come from the target of the pending transfers
  assign rvalid_o = rvalid_i[cur_idx_q];
  assign rdata_o  = rdata_i[cur_idx_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      cur_idx_q <= '0;
    end else begin
      if (accept) begin
        cur_idx_q <= sel_idx;
      end
      case ({accept, rvalid_o})
        2'b10:   pending_q <= pending_q + 1'b1;
        2'b01:   pending_q <= pending_q - 1'b1;
        default: pending_q <= pending_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/obi_rr_arbiter.sv */
// N-to-one round robin arbiter; slave must answer in request order, req held while queue is full
`default_nettype none

module obi_rr_arbiter #(
  parameter int unsigned NMASTER = 3,
  parameter int unsigned IDX_W   = bus_pkg::MST_IDX_W
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic [NMASTER-1:0]                      req_i,
  input  wire logic [NMASTER-1:0]                      we_i,
  input  wire logic [NMASTER-1:0][bus_pkg::ADDR_W-1:0] addr_i,
  input  wire logic [NMASTER-1:0][bus_pkg::DATA_W-1:0] wdata_i,
  output logic [NMASTER-1:0]                           gnt_o,
  output logic [NMASTER-1:0]                           rvalid_o,
  output logic [NMASTER-1:0][bus_pkg::DATA_W-1:0]      rdata_o,
  output logic                                         req_o,
  output logic                                         we_o,
  output logic [bus_pkg::ADDR_W-1:0]                   addr_o,
  output logic [bus_pkg::DATA_W-1:0]                   wdata_o,
  input  wire logic                                    gnt_i,
  input  wire logic                                    rvalid_i,
  input  wire logic [bus_pkg::DATA_W-1:0]              rdata_i
);

  localparam int unsigned DEPTH = bus_pkg::ORDER_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [IDX_W-1:0] prio_q;
  logic [IDX_W-1:0] winner;
  logic             found;
  logic             push;
  logic             pop;
  logic             full;
  logic [IDX_W-1:0] order_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [IDX_W-1:0] head_idx;

  // ------------------------------------------------------------
  // Round robin pick, starting at the priority pointer
  // ------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    winner = '0;
    found  = 1'b0;
    for (int unsigned k = 0; k < NMASTER; k++) begin
      cand = (int'(prio_q) + k) % NMASTER;
      if (!found && req_i[cand]) begin
        winner = IDX_W'(cand);
        found  = 1'b1;
      end
    end
  end

  assign full    = (count_q == CNT_W'(DEPTH));
  assign req_o   = found && !full;
  assign we_o    = we_i[winner];
  assign addr_o  = addr_i[winner];
  assign wdata_o = wdata_i[winner];

  assign push     = req_o && gnt_i;
  assign pop      = rvalid_i;
  assign head_idx = order_mem[rd_ptr_q];

  always_comb begin
    for (int m = 0; m < NMASTER; m++) begin
      gnt_o[m]    = push && (winner == IDX_W'(m));
      rvalid_o[m] = rvalid_i && (head_idx == IDX_W'(m));
      rdata_o[m]  = rdata_i;
    end
  end

  // ------------------------------------------------------------
  // Order queue of granted master indexes
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      order_mem[wr_ptr_q] <= winner;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        prio_q   <= (int'(winner) == NMASTER - 1) ? '0 : winner + 1'b1;
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb.f */
src/bus_pkg.sv
src/obi_demux.sv
src/obi_rr_arbiter.sv
src/ext_xbar.sv
src/ext_bus.sv
bench/tb_mem_slave.sv
bench/tb_ext_bus.sv
